// File: hdl/mbu_settings.svh
// Constants for the memory bank unit
// Bank count, I/O window base and control unit address codes

`ifndef MBU_SETTINGS_SVH
`define MBU_SETTINGS_SVH

////////////////////////////////////////
// Register file size
////////////////////////////////////////

// Eight bank registers, MB0 to MB7
`define MBU_NUM_BANKS 8

////////////////////////////////////////
// I/O window
////////////////////////////////////////

// First I/O port of the window, one port per bank
`define MBU_IO_BASE 8'h08

////////////////////////////////////////
// Control unit address codes
////////////////////////////////////////

// Same codes on raddr and waddr
`define MBU_CU_MBP       5'd12
`define MBU_CU_MBP_FLAGS 5'd13
`define MBU_CU_FLAGS     5'd14

// Group in waddr bits 4 to 2, low bits pick MB0 to MB3
`define MBU_CU_AR_MBX    3'b001

`endif

// File: hdl/mbu_pkg.sv
// Shared types for the memory bank unit
// Decoded opcode, request source and bank enable state

`default_nettype none

package mbu_pkg;

   ////////////////////////////////////////
   // Decoded operations
   ////////////////////////////////////////

   // One opcode per recognized control unit code or I/O access
   typedef enum logic [3:0] {
      // Unknown code or I/O miss, answers with zero
      OP_NONE            = 4'd0,
      // Control unit read of the bank picked by ir
      OP_READ_MBP        = 4'd1,
      // Same, plus strobe to the flag unit
      OP_READ_MBP_FLAGS  = 4'd2,
      // Flag strobe only
      OP_READ_FLAGS      = 4'd3,
      // Control unit write of the bank picked by ir
      OP_WRITE_MBP       = 4'd4,
      // Same, plus strobe to the flag unit
      OP_WRITE_MBP_FLAGS = 4'd5,
      // Flag strobe only
      OP_WRITE_FLAGS     = 4'd6,
      // Load aext from MB0 to MB3
      OP_WRITE_AR_MBX    = 4'd7,
      // Program access through the I/O window
      OP_IO_READ         = 4'd8,
      OP_IO_WRITE        = 4'd9
   } mbu_op_e;

   ////////////////////////////////////////
   // Request source
   ////////////////////////////////////////

   // Carried with each op and echoed on the response
   typedef enum logic {
      SRC_CU = 1'b0,
      SRC_IO = 1'b1
   } mbu_src_e;

   ////////////////////////////////////////
   // Bank enable state
   ////////////////////////////////////////

   // Default until the first I/O write, then live
   typedef enum logic {
      BANKS_DEFAULT = 1'b0,
      BANKS_LIVE    = 1'b1
   } mbu_bank_state_e;

endpackage

`default_nettype wire

// File: hdl/mbu_op_if.sv
// Decoded operation channel
// Valid/ready handshake from the decoder to the register file

`timescale 1ns/10ps
`default_nettype none

`include "mbu_settings.svh"

interface mbu_op_if;
   import mbu_pkg::*;

   // Bank selector width, 3 bits for eight banks
   localparam int unsigned SEL_W = $clog2(`MBU_NUM_BANKS);

   // Handshake
   logic             valid;
   logic             ready;

   // Payload, held steady while valid and not ready
   mbu_op_e          op;
   logic [SEL_W-1:0] sel;
   logic [7:0]       wdata;
   mbu_src_e         src;

   // Decoder side
   modport source (output valid, output op, output sel, output wdata, output src,
                   input ready);

   // Register file side
   modport sink (input valid, input op, input sel, input wdata, input src,
                 output ready);

endinterface

`default_nettype wire

// File: hdl/mbu_decode.sv
// Request front end of the memory bank unit
// Arbitration with I/O first, address decode, decoded-op register

`timescale 1ns/10ps
`default_nettype none

`include "mbu_settings.svh"

module mbu_decode (
   input  logic        clk,
   input  logic        rst_n,
   // Control unit request
   input  logic        cu_valid,
   output logic        cu_ready,
   input  logic [4:0]  raddr,
   input  logic        ruen,
   input  logic [4:0]  waddr,
   input  logic        wuen,
   input  logic [11:0] ir,
   input  logic [7:0]  ibus_in,
   // I/O request
   input  logic        io_valid,
   output logic        io_ready,
   input  logic [7:0]  io_addr,
   input  logic        sysdev,
   input  logic        io_write,
   input  logic [7:0]  db_in,
   // Decoded op out
   mbu_op_if.source    op_o
);
   import mbu_pkg::*;

   localparam int unsigned SEL_W = $clog2(`MBU_NUM_BANKS);

   logic             load;
   logic             take_io;
   logic             take_cu;
   logic             io_hit;
   mbu_op_e          io_op;
   mbu_op_e          cu_op;
   logic [SEL_W-1:0] cu_sel;

   // Map the shared 5-bit codes, read or write flavour
   function automatic mbu_op_e cu_code_op(input logic [4:0] code, input logic wr);
      mbu_op_e op;
      case (code)
         `MBU_CU_MBP:       op = wr ? OP_WRITE_MBP : OP_READ_MBP;
         `MBU_CU_MBP_FLAGS: op = wr ? OP_WRITE_MBP_FLAGS : OP_READ_MBP_FLAGS;
         `MBU_CU_FLAGS:     op = wr ? OP_WRITE_FLAGS : OP_READ_FLAGS;
         default:           op = OP_NONE;
      endcase
      return op;
   endfunction

   ////////////////////////////////////////
   // Arbitration
   ////////////////////////////////////////

   // Stage takes a new op when empty or draining this edge
   assign load     = !op_o.valid || op_o.ready;
   // I/O wins, control unit waits while I/O is pending
   assign io_ready = load;
   assign cu_ready = load && !io_valid;
   assign take_io  = io_valid && io_ready;
   assign take_cu  = cu_valid && cu_ready;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   // Window 0x08..0x0F, only with sysdev asserted
   assign io_hit = sysdev && (io_addr >= `MBU_IO_BASE) &&
                   (io_addr < (`MBU_IO_BASE + 8'(`MBU_NUM_BANKS)));
   assign io_op  = !io_hit ? OP_NONE : (io_write ? OP_IO_WRITE : OP_IO_READ);

   always_comb begin
      cu_op  = OP_NONE;
      // ir picks the bank for MBP forms
      cu_sel = ir[SEL_W-1:0];
      if (ruen) begin
         // Read decode has priority over a simultaneous write
         cu_op = cu_code_op(raddr, 1'b0);
      end else if (wuen) begin
         if (waddr[4:2] == `MBU_CU_AR_MBX) begin
            // AR extension, MB0..MB3 from waddr low bits
            cu_op  = OP_WRITE_AR_MBX;
            cu_sel = SEL_W'(waddr[1:0]);
         end else begin
            cu_op = cu_code_op(waddr, 1'b1);
         end
      end
   end

   ////////////////////////////////////////
   // Decoded-op register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_o.valid <= 1'b0;
      end else if (load) begin
         op_o.valid <= take_io || take_cu;
      end
   end

   // Payload only moves on an accepted request
   always_ff @(posedge clk) begin
      if (take_io) begin
         op_o.op    <= io_op;
         op_o.sel   <= io_addr[SEL_W-1:0];
         op_o.wdata <= db_in;
         op_o.src   <= SRC_IO;
      end else if (take_cu) begin
         op_o.op    <= cu_op;
         op_o.sel   <= cu_sel;
         op_o.wdata <= ibus_in;
         op_o.src   <= SRC_CU;
      end
   end

   // A stalled op keeps every field until the register file takes it
   a_op_stable : assert property (@(posedge clk) disable iff (!rst_n)
      op_o.valid && !op_o.ready |=>
         op_o.valid && $stable(op_o.op) && $stable(op_o.sel) &&
         $stable(op_o.wdata) && $stable(op_o.src))
      else $error("decoded op changed while stalled");

endmodule

`default_nettype wire

// File: hdl/mbu_regfile.sv
// Back end of the memory bank unit
// Bank registers, enable state, aext register
// Response register and flag unit strobes

`timescale 1ns/10ps
`default_nettype none

`include "mbu_settings.svh"

module mbu_regfile (
   input  logic             clk,
   input  logic             rst_n,
   // Front-panel ROM switch, sets the power-on default
   input  logic             fprom,
   // Decoded op in
   mbu_op_if.sink           op_i,
   // Response
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output mbu_pkg::mbu_src_e rsp_src,
   output logic [7:0]       rsp_data,
   // Address extension
   output logic [7:0]       aext,
   // Flag unit strobes
   output logic             write_flags,
   output logic             write_mbp_flags,
   output logic             read_flags,
   output logic             read_mbp_flags
);
   import mbu_pkg::*;

   logic [7:0]      bank_q [`MBU_NUM_BANKS];
   mbu_bank_state_e bank_state;
   logic            take;
   logic [7:0]      dflt_value;
   logic [7:0]      rd_value;
   logic [7:0]      rsp_next;
   logic            bank_wr;

   ////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////

   // Free when the response slot is empty or being taken
   assign op_i.ready = !rsp_valid || rsp_ready;
   assign take       = op_i.valid && op_i.ready;

   ////////////////////////////////////////
   // Bank registers
   ////////////////////////////////////////

   // 0x80 selects ROM space when the switch is set
   assign dflt_value = {fprom, 7'b000_0000};

   // Banks hide behind the default until enabled
   assign rd_value = (bank_state == BANKS_LIVE) ? bank_q[op_i.sel] : dflt_value;

   assign bank_wr = take && ((op_i.op == OP_WRITE_MBP) ||
                             (op_i.op == OP_WRITE_MBP_FLAGS) ||
                             (op_i.op == OP_IO_WRITE));

   // No reset, contents undefined until written
   always_ff @(posedge clk) begin
      if (bank_wr) begin
         bank_q[op_i.sel] <= op_i.wdata;
      end
   end

   // First I/O write turns the banks live, and stores its own data
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bank_state <= BANKS_DEFAULT;
      end else if (take && (op_i.op == OP_IO_WRITE)) begin
         bank_state <= BANKS_LIVE;
      end
   end

   ////////////////////////////////////////
   // Address extension
   ////////////////////////////////////////

   // Loads with the response, so aext is current when the response shows
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         aext <= dflt_value;
      end else if (take && (op_i.op == OP_WRITE_AR_MBX)) begin
         aext <= rd_value;
      end
   end

   ////////////////////////////////////////
   // Response
   ////////////////////////////////////////

   // Reads return the bank, writes echo their data
   // Flag-only and unknown codes answer with zero
   always_comb begin
      case (op_i.op)
         OP_READ_MBP, OP_READ_MBP_FLAGS, OP_IO_READ: rsp_next = rd_value;
         OP_WRITE_MBP, OP_WRITE_MBP_FLAGS, OP_IO_WRITE: rsp_next = op_i.wdata;
         // New aext value
         OP_WRITE_AR_MBX: rsp_next = rd_value;
         default: rsp_next = 8'h00;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (take) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         rsp_src  <= op_i.src;
         rsp_data <= rsp_next;
      end
   end

   ////////////////////////////////////////
   // Flag unit strobes
   ////////////////////////////////////////

   // One cycle, first cycle of the response, never repeated on a stall
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         write_flags     <= 1'b0;
         write_mbp_flags <= 1'b0;
         read_flags      <= 1'b0;
         read_mbp_flags  <= 1'b0;
      end else begin
         write_flags     <= take && (op_i.op == OP_WRITE_FLAGS);
         write_mbp_flags <= take && (op_i.op == OP_WRITE_MBP_FLAGS);
         read_flags      <= take && (op_i.op == OP_READ_FLAGS);
         read_mbp_flags  <= take && (op_i.op == OP_READ_MBP_FLAGS);
      end
   end

   // Strobes are exclusive and ride on a valid response
   a_strobe_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({write_flags, write_mbp_flags, read_flags, read_mbp_flags}) &&
      ((write_flags || write_mbp_flags || read_flags || read_mbp_flags) -> rsp_valid))
      else $error("strobe overlap or strobe without response");

   // A response stays put until the consumer takes it
   a_rsp_hold : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_src) && $stable(rsp_data))
      else $error("response dropped or changed before rsp_ready");

endmodule

`default_nettype wire

// File: hdl/mbu.sv
// Memory bank unit, RTL top level
// Decoder and register file joined by one op channel

`timescale 1ns/10ps
`default_nettype none

module mbu (
   input  logic              clk,
   input  logic              rst_n,
   // Control unit request
   input  logic              cu_valid,
   output logic              cu_ready,
   input  logic [4:0]        raddr,
   input  logic              ruen,
   input  logic [4:0]        waddr,
   input  logic              wuen,
   input  logic [11:0]       ir,
   input  logic [7:0]        ibus_in,
   // I/O request
   input  logic              io_valid,
   output logic              io_ready,
   input  logic [7:0]        io_addr,
   input  logic              sysdev,
   input  logic              io_write,
   input  logic [7:0]        db_in,
   // Response, shared by both sources
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output mbu_pkg::mbu_src_e rsp_src,
   output logic [7:0]        rsp_data,
   // Front-panel ROM switch
   input  logic              fprom,
   // Address extension, bits 23..16
   output logic [7:0]        aext,
   // To the flag unit
   output logic              write_flags,
   output logic              write_mbp_flags,
   output logic              read_flags,
   output logic              read_mbp_flags
);

   // Decoded op between the two stages
   mbu_op_if op_if ();

   ////////////////////////////////////////
   // Stage 1, arbitration and decode
   ////////////////////////////////////////

   mbu_decode u_decode (
      .clk      (clk),
      .rst_n    (rst_n),
      .cu_valid (cu_valid),
      .cu_ready (cu_ready),
      .raddr    (raddr),
      .ruen     (ruen),
      .waddr    (waddr),
      .wuen     (wuen),
      .ir       (ir),
      .ibus_in  (ibus_in),
      .io_valid (io_valid),
      .io_ready (io_ready),
      .io_addr  (io_addr),
      .sysdev   (sysdev),
      .io_write (io_write),
      .db_in    (db_in),
      .op_o     (op_if.source)
   );

   ////////////////////////////////////////
   // Stage 2, register access and response
   ////////////////////////////////////////

   mbu_regfile u_regfile (
      .clk             (clk),
      .rst_n           (rst_n),
      .fprom           (fprom),
      .op_i            (op_if.sink),
      .rsp_valid       (rsp_valid),
      .rsp_ready       (rsp_ready),
      .rsp_src         (rsp_src),
      .rsp_data        (rsp_data),
      .aext            (aext),
      .write_flags     (write_flags),
      .write_mbp_flags (write_mbp_flags),
      .read_flags      (read_flags),
      .read_mbp_flags  (read_mbp_flags)
   );

endmodule

`default_nettype wire

// File: bench/mbu_clkgen.sv
// Clock and reset generator for the memory bank unit testbench
// 10 ns clock, active-low reset held for two rising edges

`timescale 1ns/10ps
`default_nettype none

module mbu_clkgen #(
   parameter int PERIOD_NS = 10
) (
   output logic clk,
   output logic rst_n
);

   event reset_evt;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Power-on reset, then one more reset per request
   initial begin
      rst_n = 1'b0;
      forever begin
         repeat (2) @(posedge clk);
         // Release on the falling edge, away from the sampling edge
         @(negedge clk);
         rst_n = 1'b1;
         @(reset_evt);
         rst_n = 1'b0;
      end
   end

   // Called on a falling edge, returns when reset is released
   task automatic apply_reset();
      ->reset_evt;
      @(posedge rst_n);
   endtask

endmodule

`default_nettype wire

// File: bench/mbu_checker.sv
// Response monitor for the memory bank unit testbench
// Expected-response queue filled by the testbench top
// Compares data, source, aext and flag strobes, checks arbitration
// Keeps per-test and total counts

`timescale 1ns/10ps
`default_nettype none

module mbu_checker (
   input logic              clk,
   input logic              rst_n,
   // Request side, for the arbitration check
   input logic              io_valid,
   input logic              cu_valid,
   input logic              cu_ready,
   // Response side
   input logic              rsp_valid,
   input logic              rsp_ready,
   input mbu_pkg::mbu_src_e rsp_src,
   input logic [7:0]        rsp_data,
   input logic [7:0]        aext,
   input logic              write_flags,
   input logic              write_mbp_flags,
   input logic              read_flags,
   input logic              read_mbp_flags
);
   import mbu_pkg::*;

   // Entry layout: src, strobes {wf, wmf, rf, rmf}, data, aext
   logic [20:0] exp_q [$];
   logic [20:0] head;
   logic [3:0]  stb;
   // Next valid response is a new one, strobes allowed
   logic        fresh = 1'b1;
   string       test_name = "none";
   int          pending = 0;
   int          n_tests = 0;
   int          n_rsp = 0;
   int          n_err = 0;
   int          test_rsp = 0;
   int          test_err = 0;

   ////////////////////////////////////////
   // Called from the testbench top
   ////////////////////////////////////////

   function automatic void expect_rsp(input logic [20:0] entry);
      exp_q.push_back(entry);
      pending = exp_q.size();
   endfunction

   function automatic void begin_test(input string name);
      test_name = name;
      test_rsp  = 0;
      test_err  = 0;
   endfunction

   // One summary line per test
   function automatic void end_test();
      n_tests++;
      $display("%s: %0d responses, %0d errors", test_name, test_rsp, test_err);
   endfunction

   ////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////

   function automatic void report_failure(input string msg);
      $display("ERROR in %s: %s", test_name, msg);
      test_err++;
      n_err++;
   endfunction

   function automatic void compare_field(input string what, input logic [7:0] exp_v,
                                         input logic [7:0] act_v);
      if (act_v !== exp_v) begin
         $display("MISMATCH %s %s: expected %02h, actual %02h",
                  test_name, what, exp_v, act_v);
         test_err++;
         n_err++;
      end
   endfunction

   ////////////////////////////////////////
   // Monitor
   ////////////////////////////////////////

   // Sampled on the rising edge, inputs change on the falling edge
   always @(posedge clk) begin
      stb = {write_flags, write_mbp_flags, read_flags, read_mbp_flags};
      if (!rst_n) begin
         fresh = 1'b1;
      end else begin
         // I/O has priority, the control unit must wait
         if (io_valid && cu_valid && cu_ready) begin
            report_failure("control unit was ready while an I/O request was waiting");
         end
         if (!rsp_valid) begin
            if (stb != 4'h0) begin
               report_failure("flag strobe fired without a response");
            end
            fresh = 1'b1;
         end else if (exp_q.size() == 0) begin
            report_failure("response arrived with no request outstanding");
            fresh = rsp_ready;
         end else begin
            head = exp_q[0];
            // Strobe only in the first cycle of its response
            if (fresh) begin
               compare_field("strobes", {4'h0, head[19:16]}, {4'h0, stb});
            end else if (stb != 4'h0) begin
               report_failure("flag strobe repeated while the response was stalled");
            end
            if (rsp_ready) begin
               compare_field("src", {7'h00, head[20]}, {7'h00, rsp_src});
               compare_field("data", head[15:8], rsp_data);
               compare_field("aext", head[7:0], aext);
               void'(exp_q.pop_front());
               pending = exp_q.size();
               test_rsp++;
               n_rsp++;
            end
            fresh = rsp_ready;
         end
      end
   end

endmodule

`default_nettype wire

// File: bench/mbu_tb.sv
// Testbench top for the memory bank unit
// Falling-edge stimulus, Galois LFSR, reference model
// Directed tests, random arbitration test with back-pressure, watchdog

`timescale 1ns/10ps
`default_nettype none

`include "mbu_settings.svh"

module mbu_tb;
   import mbu_pkg::*;

   localparam int CLK_PERIOD = 10;
   // Requests per test
   localparam int N_DEFAULTS = 16;
   localparam int N_IO_WIN   = 28;
   localparam int N_CU       = 25;
   localparam int N_AR       = 5;
   localparam int N_ARB      = 80;
   localparam int N_REQ      = N_DEFAULTS + N_IO_WIN + N_CU + N_AR + N_ARB;
   // 20 cycles per request plus both resets
   localparam int WATCHDOG_NS = (N_REQ * 20 + 8) * CLK_PERIOD;

   logic        clk;
   logic        rst_n;
   logic        cu_valid;
   logic        cu_ready;
   logic [4:0]  raddr;
   logic        ruen;
   logic [4:0]  waddr;
   logic        wuen;
   logic [11:0] ir;
   logic [7:0]  ibus_in;
   logic        io_valid;
   logic        io_ready;
   logic [7:0]  io_addr;
   logic        sysdev;
   logic        io_write;
   logic [7:0]  db_in;
   logic        rsp_valid;
   logic        rsp_ready;
   mbu_src_e    rsp_src;
   logic [7:0]  rsp_data;
   logic        fprom;
   logic [7:0]  aext;
   logic        write_flags;
   logic        write_mbp_flags;
   logic        read_flags;
   logic        read_mbp_flags;

   // Stimulus state
   logic [31:0] lfsr;
   logic        io_pend;
   logic        cu_pend;
   logic        bp_mode;
   // Reference model state
   logic [7:0]  m_regs [`MBU_NUM_BANKS];
   logic        m_live;
   logic [7:0]  m_aext;

   mbu_clkgen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk), .rst_n(rst_n));

   mbu uut (
      .clk(clk), .rst_n(rst_n),
      .cu_valid(cu_valid), .cu_ready(cu_ready), .raddr(raddr), .ruen(ruen),
      .waddr(waddr), .wuen(wuen), .ir(ir), .ibus_in(ibus_in),
      .io_valid(io_valid), .io_ready(io_ready), .io_addr(io_addr),
      .sysdev(sysdev), .io_write(io_write), .db_in(db_in),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_src(rsp_src),
      .rsp_data(rsp_data), .fprom(fprom), .aext(aext),
      .write_flags(write_flags), .write_mbp_flags(write_mbp_flags),
      .read_flags(read_flags), .read_mbp_flags(read_mbp_flags)
   );

   mbu_checker u_chk (
      .clk(clk), .rst_n(rst_n),
      .io_valid(io_valid), .cu_valid(cu_valid), .cu_ready(cu_ready),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_src(rsp_src),
      .rsp_data(rsp_data), .aext(aext),
      .write_flags(write_flags), .write_mbp_flags(write_mbp_flags),
      .read_flags(read_flags), .read_mbp_flags(read_mbp_flags)
   );

   ////////////////////////////////////////
   // Random source
   ////////////////////////////////////////

   // Galois LFSR stepped once per bit taken
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = 16'h0000;
      for (int i = 0; i < n; i++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Power-on default until the first I/O write
   function automatic logic [7:0] bank_value(input logic [2:0] sel);
      if (!m_live) begin
         return {fprom, 7'h00};
      end
      return m_regs[sel];
   endfunction

   // Predicts the response of one accepted request and updates the model
   // Result packs src, strobes {wf, wmf, rf, rmf}, data and aext
   function automatic logic [20:0] predict(
      input logic        is_io,
      input logic [4:0]  ra,
      input logic        ru,
      input logic [4:0]  wa,
      input logic        wu,
      input logic [11:0] irv,
      input logic [7:0]  ib,
      input logic [7:0]  ia,
      input logic        sd,
      input logic        iw,
      input logic [7:0]  db
   );
      logic [3:0] stb;
      logic [7:0] data;
      stb  = 4'h0;
      data = 8'h00;
      if (is_io) begin
         // Misses and sysdev low answer zero and change nothing
         if (sd && (ia >= `MBU_IO_BASE) && (ia <= `MBU_IO_BASE + 8'h07)) begin
            if (iw) begin
               m_regs[ia[2:0]] = db;
               m_live = 1'b1;
               data = db;
            end else begin
               data = bank_value(ia[2:0]);
            end
         end
      end else if (ru) begin
         // Read decode wins over a simultaneous write
         case (ra)
            `MBU_CU_MBP: data = bank_value(irv[2:0]);
            `MBU_CU_MBP_FLAGS: begin
               data = bank_value(irv[2:0]);
               stb  = 4'b0001;
            end
            `MBU_CU_FLAGS: stb = 4'b0010;
            default: data = 8'h00;
         endcase
      end else if (wu) begin
         if (wa[4:2] == `MBU_CU_AR_MBX) begin
            // MB0 to MB3 into the address extension
            m_aext = bank_value({1'b0, wa[1:0]});
            data   = m_aext;
         end else begin
            case (wa)
               `MBU_CU_MBP: begin
                  m_regs[irv[2:0]] = ib;
                  data = ib;
               end
               `MBU_CU_MBP_FLAGS: begin
                  m_regs[irv[2:0]] = ib;
                  data = ib;
                  stb  = 4'b0100;
               end
               `MBU_CU_FLAGS: stb = 4'b1000;
               default: data = 8'h00;
            endcase
         end
      end
      return {is_io, stb, data, m_aext};
   endfunction

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // One cycle from a falling edge to the next
   task automatic step();
      logic [15:0] r;
      io_valid = io_pend;
      cu_valid = cu_pend;
      if (bp_mode) begin
         r = rand_bits(1);
         rsp_ready = r[0];
      end else begin
         rsp_ready = 1'b1;
      end
      // Ready settles here and the handshake completes on the next rising edge
      #1;
      if (io_valid && io_ready) begin
         u_chk.expect_rsp(predict(1'b1, raddr, ruen, waddr, wuen, ir, ibus_in,
                                  io_addr, sysdev, io_write, db_in));
         io_pend = 1'b0;
      end
      if (cu_valid && cu_ready) begin
         u_chk.expect_rsp(predict(1'b0, raddr, ruen, waddr, wuen, ir, ibus_in,
                                  io_addr, sysdev, io_write, db_in));
         cu_pend = 1'b0;
      end
      @(negedge clk);
   endtask

   task automatic io_request(input logic [7:0] a, input logic sd, input logic w,
                             input logic [7:0] d);
      io_addr  = a;
      sysdev   = sd;
      io_write = w;
      db_in    = d;
      io_pend  = 1'b1;
      while (io_pend) step();
   endtask

   task automatic cu_request(input logic [4:0] ra, input logic ru, input logic [4:0] wa,
                             input logic wu, input logic [2:0] sel, input logic [7:0] d);
      raddr   = ra;
      ruen    = ru;
      waddr   = wa;
      wuen    = wu;
      ir      = {9'h000, sel};
      ibus_in = d;
      cu_pend = 1'b1;
      while (cu_pend) step();
   endtask

   // Half the addresses land in the window and sysdev is mostly set
   task automatic load_random_io();
      logic [15:0] m;
      logic [15:0] a;
      logic [15:0] w;
      logic [15:0] sd;
      logic [15:0] d;
      m  = rand_bits(1);
      a  = rand_bits(8);
      w  = rand_bits(1);
      sd = rand_bits(2);
      d  = rand_bits(8);
      io_addr  = m[0] ? a[7:0] : {5'b00001, a[2:0]};
      sysdev   = |sd[1:0];
      io_write = w[0];
      db_in    = d[7:0];
      io_pend  = 1'b1;
   endtask

   task automatic load_random_cu();
      logic [15:0] k;
      logic [15:0] s;
      logic [15:0] d;
      logic [15:0] c;
      k = rand_bits(3);
      s = rand_bits(3);
      d = rand_bits(8);
      c = rand_bits(5);
      raddr = 5'd0;
      ruen  = 1'b0;
      waddr = 5'd0;
      wuen  = 1'b0;
      case (k[2:0])
         3'd0: begin
            raddr = `MBU_CU_MBP;
            ruen  = 1'b1;
         end
         3'd1: begin
            waddr = `MBU_CU_MBP;
            wuen  = 1'b1;
         end
         3'd2: begin
            raddr = `MBU_CU_MBP_FLAGS;
            ruen  = 1'b1;
         end
         3'd3: begin
            waddr = `MBU_CU_MBP_FLAGS;
            wuen  = 1'b1;
         end
         3'd4: begin
            raddr = `MBU_CU_FLAGS;
            ruen  = 1'b1;
         end
         3'd5: begin
            waddr = `MBU_CU_FLAGS;
            wuen  = 1'b1;
         end
         3'd6: begin
            waddr = {`MBU_CU_AR_MBX, c[1:0]};
            wuen  = 1'b1;
         end
         // Random read code that may be unused and answer zero
         default: begin
            raddr = c[4:0];
            ruen  = 1'b1;
         end
      endcase
      ir      = {9'h000, s[2:0]};
      ibus_in = d[7:0];
      cu_pend = 1'b1;
   endtask

   // Idle until every expected response is checked
   task automatic drain();
      while (u_chk.pending != 0) step();
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   initial begin
      logic [15:0] r;
      int io_left;
      int cu_left;
      lfsr      = 32'ha6eb_52d6;
      cu_valid  = 1'b0;
      raddr     = 5'd0;
      ruen      = 1'b0;
      waddr     = 5'd0;
      wuen      = 1'b0;
      ir        = 12'h000;
      ibus_in   = 8'h00;
      io_valid  = 1'b0;
      io_addr   = 8'h00;
      sysdev    = 1'b0;
      io_write  = 1'b0;
      db_in     = 8'h00;
      rsp_ready = 1'b1;
      fprom     = 1'b1;
      io_pend   = 1'b0;
      cu_pend   = 1'b0;
      bp_mode   = 1'b0;
      m_live    = 1'b0;
      m_aext    = {fprom, 7'h00};
      @(posedge rst_n);

      // Defaults with the ROM switch set and then clear after a second reset
      u_chk.begin_test("defaults");
      for (int i = 0; i < 8; i++) io_request(`MBU_IO_BASE + 8'(i), 1'b1, 1'b0, 8'h00);
      drain();
      fprom = 1'b0;
      u_clk.apply_reset();
      m_live = 1'b0;
      m_aext = {fprom, 7'h00};
      for (int i = 0; i < 8; i++) cu_request(`MBU_CU_MBP, 1'b1, 5'd0, 1'b0, 3'(i), 8'h00);
      drain();
      u_chk.end_test();

      // First I/O window write enables the banks
      u_chk.begin_test("io_window");
      for (int i = 0; i < 8; i++) begin
         r = rand_bits(8);
         io_request(`MBU_IO_BASE + 8'(i), 1'b1, 1'b1, r[7:0]);
      end
      for (int i = 0; i < 8; i++) io_request(`MBU_IO_BASE + 8'(i), 1'b1, 1'b0, 8'h00);
      r = rand_bits(8);
      io_request(8'h07, 1'b1, 1'b1, r[7:0]);
      io_request(8'h10, 1'b1, 1'b1, r[7:0]);
      io_request(8'h88, 1'b1, 1'b1, r[7:0]);
      io_request(`MBU_IO_BASE + 8'h01, 1'b0, 1'b1, r[7:0]);
      // Misses must have left every bank alone
      for (int i = 0; i < 8; i++) io_request(`MBU_IO_BASE + 8'(i), 1'b1, 1'b0, 8'h00);
      drain();
      u_chk.end_test();

      // Control unit codes with ir picking the bank
      u_chk.begin_test("cu_access");
      for (int i = 0; i < 8; i++) begin
         r = rand_bits(8);
         cu_request(5'd0, 1'b0, `MBU_CU_MBP, 1'b1, 3'(i), r[7:0]);
         cu_request(`MBU_CU_MBP, 1'b1, 5'd0, 1'b0, 3'(i), 8'h00);
      end
      r = rand_bits(8);
      cu_request(5'd0, 1'b0, `MBU_CU_MBP_FLAGS, 1'b1, 3'd5, r[7:0]);
      cu_request(`MBU_CU_MBP_FLAGS, 1'b1, 5'd0, 1'b0, 3'd5, 8'h00);
      cu_request(`MBU_CU_FLAGS, 1'b1, 5'd0, 1'b0, 3'd5, 8'h00);
      cu_request(5'd0, 1'b0, `MBU_CU_FLAGS, 1'b1, 3'd5, r[7:0]);
      cu_request(5'd0, 1'b1, 5'd0, 1'b0, 3'd2, 8'h00);
      cu_request(5'd31, 1'b1, 5'd0, 1'b0, 3'd2, 8'h00);
      cu_request(5'd0, 1'b0, 5'd20, 1'b1, 3'd2, r[7:0]);
      // With both enables the read decode wins
      cu_request(`MBU_CU_MBP, 1'b1, `MBU_CU_MBP_FLAGS, 1'b1, 3'd3, ~r[7:0]);
      // Bank 3 still holds its old value
      cu_request(`MBU_CU_MBP, 1'b1, `MBU_CU_MBP, 1'b0, 3'd3, ~r[7:0]);
      drain();
      u_chk.end_test();

      // AR extension from MB0 to MB3
      u_chk.begin_test("ar_extension");
      for (int w = 4; w < 8; w++) cu_request(5'd0, 1'b0, 5'(w), 1'b1, 3'd0, 8'h00);
      cu_request(5'd0, 1'b1, 5'd6, 1'b1, 3'd0, 8'h00);
      drain();
      u_chk.end_test();

      // Both sources busy under random back-pressure on the response
      u_chk.begin_test("arbitration");
      bp_mode = 1'b1;
      io_left = N_ARB / 2;
      cu_left = N_ARB / 2;
      while (io_left > 0 || cu_left > 0 || io_pend || cu_pend) begin
         if (!io_pend && io_left > 0) begin
            load_random_io();
            io_left--;
         end
         if (!cu_pend && cu_left > 0) begin
            load_random_cu();
            cu_left--;
         end
         step();
      end
      bp_mode = 1'b0;
      drain();
      u_chk.end_test();

      $display("%0d tests, %0d responses, %0d errors", u_chk.n_tests, u_chk.n_rsp,
               u_chk.n_err);
      if (u_chk.n_err == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: timeout, the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: mbu.f
+incdir+hdl
hdl/mbu_pkg.sv
hdl/mbu_op_if.sv
hdl/mbu_decode.sv
hdl/mbu_regfile.sv
hdl/mbu.sv
bench/mbu_clkgen.sv
bench/mbu_checker.sv
bench/mbu_tb.sv

// File: Makefile
TOP = mbu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mbu.f
	obj_dir/V$(TOP) | tee sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
